// ==== logic/icache_pkg.sv ====
// cache geometry, field types and refill states, imported by each instruction cache module
package icache_pkg;

  // ========================================
  // geometry
  // ========================================
  localparam int ADDR_W     = 32;
  localparam int WORD_W     = 32;
  localparam int LINE_WORDS = 4;
  localparam int SETS       = 16;
  // one PLRU bit per set only covers two ways
  localparam int WAYS       = 2;
  localparam int OFS_W      = 4;
  localparam int IDX_W      = 4;
  localparam int TAG_W      = ADDR_W - IDX_W - OFS_W;

  // ========================================
  // field types
  // ========================================
  typedef logic [ADDR_W-1:0]            addr_t;
  typedef logic [WORD_W-1:0]            word_t;
  typedef logic [TAG_W-1:0]             tag_t;
  typedef logic [IDX_W-1:0]             index_t;
  typedef logic [$clog2(WAYS)-1:0]      way_t;
  typedef logic [$clog2(LINE_WORDS)-1:0] beat_t;
  // word 0 sits in the low bits
  typedef logic [LINE_WORDS*WORD_W-1:0] line_t;

  // refill engine states
  typedef enum logic [1:0] {
    IDLE,
    MISS,
    REFILL
  } refill_state_e;

endpackage

// ==== logic/icache_arrays.sv ====
// tag, valid and data storage per way plus PLRU bits, read one cycle after the index
`timescale 1ns/1ps

module icache_arrays (
  input  logic                                      clk,
  input  logic                                      rst_n,
  input  icache_pkg::index_t                        rd_index_i,
  input  logic                                      wr_en_i,
  input  icache_pkg::way_t                          wr_way_i,
  input  icache_pkg::index_t                        wr_index_i,
  input  icache_pkg::tag_t                          wr_tag_i,
  input  icache_pkg::line_t                         wr_line_i,
  input  logic                                      clr_en_i,
  input  icache_pkg::index_t                        clr_index_i,
  input  icache_pkg::way_t                          clr_way_i,
  input  logic                                      hit_en_i,
  input  icache_pkg::way_t                          hit_way_i,
  input  icache_pkg::index_t                        victim_index_i,
  output icache_pkg::tag_t  [icache_pkg::WAYS-1:0]  rd_tag_o,
  output logic              [icache_pkg::WAYS-1:0]  rd_valid_o,
  output icache_pkg::line_t [icache_pkg::WAYS-1:0]  rd_line_o,
  output icache_pkg::way_t                          victim_way_o
);

  import icache_pkg::*;

  tag_t                        tag_mem  [WAYS][SETS];
  line_t                       data_mem [WAYS][SETS];
  logic [WAYS-1:0][SETS-1:0]   valid_q;
  // points at the way not most recently used
  logic [SETS-1:0]             plru_q;
  // index of the data now on the read outputs
  index_t                      rd_index_q;

  // tag and data ways, read returns the old entry on a same-cycle write
  always_ff @(posedge clk) begin
    for (int w = 0; w < WAYS; w++) begin
      if (wr_en_i && wr_way_i == way_t'(w)) begin
        tag_mem[w][wr_index_i]  <= wr_tag_i;
        data_mem[w][wr_index_i] <= wr_line_i;
      end
      rd_tag_o[w]  <= tag_mem[w][rd_index_i];
      rd_line_o[w] <= data_mem[w][rd_index_i];
    end
  end

  // ========================================
  // valid and PLRU state
  // ========================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q    <= '0;
      plru_q     <= '0;
      rd_valid_o <= '0;
      rd_index_q <= '0;
    end else begin
      for (int w = 0; w < WAYS; w++) begin
        if (wr_en_i && wr_way_i == way_t'(w)) begin
          valid_q[w][wr_index_i] <= 1'b1;
        end
        if (clr_en_i && clr_way_i == way_t'(w)) begin
          valid_q[w][clr_index_i] <= 1'b0;
        end
        rd_valid_o[w] <= valid_q[w][rd_index_i];
      end
      // the hit belongs to the set on the read outputs
      if (hit_en_i) begin
        plru_q[rd_index_q] <= ~hit_way_i;
      end
      // refill wins a same-set collision
      if (wr_en_i) begin
        plru_q[wr_index_i] <= ~wr_way_i;
      end
      rd_index_q <= rd_index_i;
    end
  end

  // lowest empty way first, else the PLRU pick
  always_comb begin
    victim_way_o = plru_q[victim_index_i];
    for (int w = WAYS - 1; w >= 0; w--) begin
      if (!valid_q[w][victim_index_i]) begin
        victim_way_o = way_t'(w);
      end
    end
  end

  a_wr_clr_apart: assert property (@(posedge clk) disable iff (!rst_n)
    !(wr_en_i && clr_en_i && wr_index_i == clr_index_i && wr_way_i == clr_way_i))
    else $error("arrays: line write and invalidate hit the same entry");

endmodule

// ==== logic/icache_lookup.sv ====
// two-stage fetch pipeline of the instruction cache, instantiated by the cache top
`timescale 1ns/1ps

module icache_lookup (
  input  logic                                      clk,
  input  logic                                      rst_n,
  input  logic                                      flush_i,
  input  logic                                      req_valid_i,
  input  icache_pkg::addr_t                         req_addr_i,
  output logic                                      req_ready_o,
  output logic                                      rsp_valid_o,
  output icache_pkg::addr_t                         rsp_addr_o,
  output icache_pkg::word_t                         rsp_instr_o,
  output logic                                      rsp_fault_o,
  input  logic                                      rsp_ready_i,
  input  logic                                      inv_valid_i,
  input  icache_pkg::index_t                        inv_index_i,
  input  icache_pkg::way_t                          inv_way_i,
  output logic                                      inv_ready_o,
  input  icache_pkg::tag_t  [icache_pkg::WAYS-1:0]  rd_tag_i,
  input  logic              [icache_pkg::WAYS-1:0]  rd_valid_i,
  input  icache_pkg::line_t [icache_pkg::WAYS-1:0]  rd_line_i,
  input  logic                                      refill_done_i,
  output icache_pkg::index_t                        rd_index_o,
  output logic                                      clr_en_o,
  output icache_pkg::index_t                        clr_index_o,
  output icache_pkg::way_t                          clr_way_o,
  output logic                                      hit_en_o,
  output icache_pkg::way_t                          hit_way_o,
  output logic                                      miss_o,
  output icache_pkg::addr_t                         miss_addr_o
);

  import icache_pkg::*;

  logic             s1_valid;
  addr_t            s1_addr;
  logic             s1_fault;
  logic             s1_ready;
  logic             done_q;
  logic [WAYS-1:0]  hit_oh;
  logic             hit;
  way_t             hit_way;
  beat_t            s1_beat;
  word_t            hit_word;

  // ========================================
  // stage 0: accept, align check, array read
  // ========================================
  // stage 1 moves on when empty or when its response leaves
  assign s1_ready    = !s1_valid || (rsp_valid_o && rsp_ready_i);

  // invalidate wins over a fetch in the same cycle
  assign inv_ready_o = s1_ready;
  assign req_ready_o = s1_ready && !inv_valid_i;

  assign clr_en_o    = inv_valid_i && inv_ready_o;
  assign clr_index_o = inv_index_i;
  assign clr_way_o   = inv_way_i;

  // held index is re-read while stage 1 stalls
  assign rd_index_o  = s1_ready ? req_addr_i[OFS_W +: IDX_W] : s1_addr[OFS_W +: IDX_W];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid <= 1'b0;
      done_q   <= 1'b0;
    end else begin
      done_q <= refill_done_i;
      if (flush_i) begin
        s1_valid <= 1'b0;
      end else if (s1_ready) begin
        s1_valid <= req_valid_i && req_ready_o;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (s1_ready) begin
      s1_addr  <= req_addr_i;
      s1_fault <= req_addr_i[1:0] != 2'b00;
    end
  end

  // ========================================
  // stage 1: tag compare and word select
  // ========================================
  always_comb begin
    hit_way = '0;
    for (int w = 0; w < WAYS; w++) begin
      hit_oh[w] = rd_valid_i[w] && (rd_tag_i[w] == s1_addr[ADDR_W-1 -: TAG_W]);
      if (hit_oh[w]) begin
        hit_way = way_t'(w);
      end
    end
  end

  assign hit      = |hit_oh;
  assign s1_beat  = s1_addr[OFS_W-1:2];
  assign hit_word = rd_line_i[hit_way][s1_beat*WORD_W +: WORD_W];

  assign rsp_valid_o = s1_valid && (s1_fault || hit);
  assign rsp_addr_o  = s1_addr;
  assign rsp_fault_o = s1_fault;
  assign rsp_instr_o = s1_fault ? '0 : hit_word;

  // PLRU follows the way that actually delivered
  assign hit_en_o  = rsp_valid_o && rsp_ready_i && !s1_fault;
  assign hit_way_o = hit_way;

  // array data is one cycle stale right after a refill write
  assign miss_o      = s1_valid && !s1_fault && !hit && !flush_i && !done_q;
  assign miss_addr_o = s1_addr;

  a_rsp_stable: assert property (@(posedge clk) disable iff (!rst_n || flush_i)
    rsp_valid_o && !rsp_ready_i |=> rsp_valid_o && $stable(rsp_addr_o) &&
      $stable(rsp_instr_o) && $stable(rsp_fault_o))
    else $error("lookup: response changed while waiting for ready");

endmodule

// ==== logic/icache_refill.sv ====
// miss handling for the instruction cache, fetches a whole line by burst and writes it back
`timescale 1ns/1ps

module icache_refill (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                flush_i,
  input  logic                miss_i,
  input  icache_pkg::addr_t   miss_addr_i,
  input  icache_pkg::way_t    victim_way_i,
  input  logic                mem_ar_ready_i,
  input  logic                mem_r_valid_i,
  input  icache_pkg::word_t   mem_r_data_i,
  input  logic                mem_r_last_i,
  output logic                mem_ar_valid_o,
  output icache_pkg::addr_t   mem_ar_addr_o,
  output logic                mem_r_ready_o,
  output icache_pkg::index_t  victim_index_o,
  output logic                wr_en_o,
  output icache_pkg::way_t    wr_way_o,
  output icache_pkg::index_t  wr_index_o,
  output icache_pkg::tag_t    wr_tag_o,
  output icache_pkg::line_t   wr_line_o,
  output logic                refill_done_o
);

  import icache_pkg::*;

  refill_state_e  state_q;
  addr_t          line_addr_q;
  way_t           victim_q;
  beat_t          beat_q;
  line_t          line_buf;
  logic           flushed_q;
  logic           line_wr_q;
  logic           start;
  logic           beat_fire;

  // a flushed refill gives no done pulse, so its stale miss is masked here
  assign start     = (state_q == IDLE) && miss_i && !line_wr_q;
  assign beat_fire = (state_q == REFILL) && mem_r_valid_i;

  assign victim_index_o = miss_addr_i[OFS_W +: IDX_W];

  assign mem_ar_valid_o = state_q == MISS;
  assign mem_ar_addr_o  = {line_addr_q[ADDR_W-1:OFS_W], {OFS_W{1'b0}}};
  assign mem_r_ready_o  = state_q == REFILL;

  // ========================================
  // line write on the last beat
  // ========================================
  assign wr_en_o    = beat_fire && mem_r_last_i;
  assign wr_way_o   = victim_q;
  assign wr_index_o = line_addr_q[OFS_W +: IDX_W];
  assign wr_tag_o   = line_addr_q[ADDR_W-1 -: TAG_W];

  // last beat goes straight from the bus into the line
  always_comb begin
    wr_line_o = line_buf;
    wr_line_o[beat_q*WORD_W +: WORD_W] = mem_r_data_i;
  end

  assign refill_done_o = wr_en_o && !flushed_q && !flush_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q   <= IDLE;
      beat_q    <= '0;
      flushed_q <= 1'b0;
      line_wr_q <= 1'b0;
    end else begin
      line_wr_q <= wr_en_o;
      case (state_q)
        IDLE: begin
          beat_q    <= '0;
          flushed_q <= 1'b0;
          if (start) begin
            state_q <= MISS;
          end
        end
        MISS: begin
          if (mem_ar_ready_i) begin
            state_q <= REFILL;
          end
        end
        REFILL: begin
          if (mem_r_valid_i) begin
            beat_q <= beat_q + 1'b1;
            if (mem_r_last_i) begin
              state_q <= IDLE;
            end
          end
        end
        default: state_q <= IDLE;
      endcase
      if (flush_i && state_q != IDLE) begin
        flushed_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      line_addr_q <= miss_addr_i;
      victim_q    <= victim_way_i;
    end
    if (beat_fire) begin
      line_buf[beat_q*WORD_W +: WORD_W] <= mem_r_data_i;
    end
  end

  a_ar_stable: assert property (@(posedge clk) disable iff (!rst_n)
    mem_ar_valid_o && !mem_ar_ready_i |=> mem_ar_valid_o && $stable(mem_ar_addr_o))
    else $error("refill: burst request dropped or moved before ready");

  a_last_beat: assert property (@(posedge clk) disable iff (!rst_n)
    mem_r_valid_i && mem_r_ready_o |-> mem_r_last_i == (beat_q == beat_t'(LINE_WORDS - 1)))
    else $error("refill: last flag out of step with the beat count");

endmodule

// ==== logic/icache_top.sv ====
// instruction cache top, connects the lookup pipeline, the storage arrays and the refill engine
`timescale 1ns/1ps

module icache_top (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 flush_i,
  // fetch request
  input  logic                 req_valid_i,
  input  icache_pkg::addr_t    req_addr_i,
  output logic                 req_ready_o,
  // fetch response
  output logic                 rsp_valid_o,
  output icache_pkg::addr_t    rsp_addr_o,
  output icache_pkg::word_t    rsp_instr_o,
  output logic                 rsp_fault_o,
  input  logic                 rsp_ready_i,
  // invalidate by index and way
  input  logic                 inv_valid_i,
  input  icache_pkg::index_t   inv_index_i,
  input  icache_pkg::way_t     inv_way_i,
  output logic                 inv_ready_o,
  // memory read burst
  output logic                 mem_ar_valid_o,
  output icache_pkg::addr_t    mem_ar_addr_o,
  input  logic                 mem_ar_ready_i,
  input  logic                 mem_r_valid_i,
  input  icache_pkg::word_t    mem_r_data_i,
  input  logic                 mem_r_last_i,
  output logic                 mem_r_ready_o
);

  import icache_pkg::*;

  // array read side
  index_t              rd_index;
  tag_t   [WAYS-1:0]   rd_tag;
  logic   [WAYS-1:0]   rd_valid;
  line_t  [WAYS-1:0]   rd_line;

  // invalidate and PLRU hit update
  logic                clr_en;
  index_t              clr_index;
  way_t                clr_way;
  logic                hit_en;
  way_t                hit_way;

  // lookup to refill and back
  logic                miss;
  addr_t               miss_addr;
  logic                refill_done;
  index_t              victim_index;
  way_t                victim_way;

  // line write
  logic                wr_en;
  way_t                wr_way;
  index_t              wr_index;
  tag_t                wr_tag;
  line_t               wr_line;

  icache_lookup u_lookup (
    .clk, .rst_n, .flush_i,
    .req_valid_i, .req_addr_i, .req_ready_o,
    .rsp_valid_o, .rsp_addr_o, .rsp_instr_o, .rsp_fault_o, .rsp_ready_i,
    .inv_valid_i, .inv_index_i, .inv_way_i, .inv_ready_o,
    .rd_tag_i        (rd_tag),
    .rd_valid_i      (rd_valid),
    .rd_line_i       (rd_line),
    .refill_done_i   (refill_done),
    .rd_index_o      (rd_index),
    .clr_en_o        (clr_en),
    .clr_index_o     (clr_index),
    .clr_way_o       (clr_way),
    .hit_en_o        (hit_en),
    .hit_way_o       (hit_way),
    .miss_o          (miss),
    .miss_addr_o     (miss_addr)
  );

  icache_arrays u_arrays (
    .clk, .rst_n,
    .rd_index_i      (rd_index),
    .wr_en_i         (wr_en),
    .wr_way_i        (wr_way),
    .wr_index_i      (wr_index),
    .wr_tag_i        (wr_tag),
    .wr_line_i       (wr_line),
    .clr_en_i        (clr_en),
    .clr_index_i     (clr_index),
    .clr_way_i       (clr_way),
    .hit_en_i        (hit_en),
    .hit_way_i       (hit_way),
    .victim_index_i  (victim_index),
    .rd_tag_o        (rd_tag),
    .rd_valid_o      (rd_valid),
    .rd_line_o       (rd_line),
    .victim_way_o    (victim_way)
  );

  icache_refill u_refill (
    .clk, .rst_n, .flush_i,
    .miss_i          (miss),
    .miss_addr_i     (miss_addr),
    .victim_way_i    (victim_way),
    .mem_ar_ready_i, .mem_r_valid_i, .mem_r_data_i, .mem_r_last_i,
    .mem_ar_valid_o, .mem_ar_addr_o, .mem_r_ready_o,
    .victim_index_o  (victim_index),
    .wr_en_o         (wr_en),
    .wr_way_o        (wr_way),
    .wr_index_o      (wr_index),
    .wr_tag_o        (wr_tag),
    .wr_line_o       (wr_line),
    .refill_done_o   (refill_done)
  );

endmodule

// ==== verification/icache_mem_model.sv ====
// burst read responder for the instruction cache testbench, returns address-derived words
`timescale 1ns/1ps

module icache_mem_model (
  input  logic               clk,
  input  logic               rst_n,
  input  icache_pkg::word_t  pattern_i,
  input  logic               ar_valid_i,
  input  icache_pkg::addr_t  ar_addr_i,
  output logic               ar_ready_o,
  output logic               r_valid_o,
  output icache_pkg::word_t  r_data_o,
  output logic               r_last_o,
  input  logic               r_ready_i,
  output int                 bursts_o
);

  import icache_pkg::*;

  logic   r_fire_q;
  addr_t  base;

  // burst count and beat handshake, taken on the rising edge
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      bursts_o <= 0;
      r_fire_q <= 1'b0;
    end else begin
      if (ar_valid_i && ar_ready_o) begin
        bursts_o <= bursts_o + 1;
      end
      r_fire_q <= r_valid_o && r_ready_i;
    end
  end

  // ========================================
  // responder, driven on the falling edge
  // ========================================
  initial begin
    ar_ready_o = 1'b0;
    r_valid_o  = 1'b0;
    r_data_o   = '0;
    r_last_o   = 1'b0;
    base       = '0;
    forever begin
      @(negedge clk);
      if (ar_valid_i) begin
        repeat ($urandom % 4) @(negedge clk);
        base       = ar_addr_i;
        ar_ready_o = 1'b1;
        @(negedge clk);
        ar_ready_o = 1'b0;
        for (int beat = 0; beat < LINE_WORDS; beat++) begin
          // gap before each beat
          repeat ($urandom % 3) @(negedge clk);
          r_valid_o = 1'b1;
          r_data_o  = (base + 4 * beat) ^ pattern_i;
          r_last_o  = beat == LINE_WORDS - 1;
          do @(negedge clk); while (!r_fire_q);
          r_valid_o = 1'b0;
          r_last_o  = 1'b0;
        end
      end
    end
  end

endmodule

// ==== verification/icache_tb.sv ====
// testbench for the instruction cache, directed and random fetches checked by assertions
`timescale 1ns/1ps

module icache_tb;

  import icache_pkg::*;

  localparam int    CLK_PERIOD   = 40;
  localparam int    RESET_CYCLES = 3;
  localparam word_t PATTERN      = 32'h5a3c_0f96;
  localparam int    N_DIRECTED   = 19;
  localparam int    N_RAND       = 60;
  // worst case cycles per request with memory delays and ready gaps
  localparam int    REFILL_BOUND = 40;
  localparam int    WATCHDOG_NS  =
    CLK_PERIOD * (RESET_CYCLES + (N_DIRECTED + N_RAND) * REFILL_BOUND);

  // lines A, B and C share set 4
  localparam addr_t LINE_L = 32'h0000_0100;
  localparam addr_t LINE_A = 32'h0000_1040;
  localparam addr_t LINE_B = 32'h0000_2040;
  localparam addr_t LINE_C = 32'h0000_3040;
  localparam addr_t LINE_F = 32'h0000_5084;
  localparam addr_t LINE_G = 32'h0000_60c8;

  logic    clk = 1'b0;
  logic    rst_n;
  logic    flush;
  logic    req_valid;
  addr_t   req_addr;
  logic    req_ready;
  logic    rsp_valid;
  addr_t   rsp_addr;
  word_t   rsp_instr;
  logic    rsp_fault;
  logic    rsp_ready = 1'b0;
  logic    inv_valid;
  index_t  inv_index;
  way_t    inv_way;
  logic    inv_ready;
  logic    mem_ar_valid;
  addr_t   mem_ar_addr;
  logic    mem_ar_ready;
  logic    mem_r_valid;
  word_t   mem_r_data;
  logic    mem_r_last;
  logic    mem_r_ready;
  int      bursts;

  // scoreboard of accepted fetches
  addr_t   exp_q[$];
  int      exp_cnt = 0;
  addr_t   exp_head = '0;
  word_t   exp_instr = '0;
  logic    req_fire_q;
  logic    inv_fire_q;
  logic    bp_en = 1'b0;
  logic    bp_q;
  logic    flush_rsp = 1'b0;
  int      errors = 0;
  int      rsp_count = 0;
  int      exp_bursts = 0;
  string   test_name = "reset";

  always #(CLK_PERIOD / 2) clk = ~clk;

  icache_top u_dut (
    .clk, .rst_n,
    .flush_i        (flush),
    .req_valid_i    (req_valid),
    .req_addr_i     (req_addr),
    .req_ready_o    (req_ready),
    .rsp_valid_o    (rsp_valid),
    .rsp_addr_o     (rsp_addr),
    .rsp_instr_o    (rsp_instr),
    .rsp_fault_o    (rsp_fault),
    .rsp_ready_i    (rsp_ready),
    .inv_valid_i    (inv_valid),
    .inv_index_i    (inv_index),
    .inv_way_i      (inv_way),
    .inv_ready_o    (inv_ready),
    .mem_ar_valid_o (mem_ar_valid),
    .mem_ar_addr_o  (mem_ar_addr),
    .mem_ar_ready_i (mem_ar_ready),
    .mem_r_valid_i  (mem_r_valid),
    .mem_r_data_i   (mem_r_data),
    .mem_r_last_i   (mem_r_last),
    .mem_r_ready_o  (mem_r_ready)
  );

  icache_mem_model u_mem (
    .clk, .rst_n,
    .pattern_i  (PATTERN),
    .ar_valid_i (mem_ar_valid),
    .ar_addr_i  (mem_ar_addr),
    .ar_ready_o (mem_ar_ready),
    .r_valid_o  (mem_r_valid),
    .r_data_o   (mem_r_data),
    .r_last_o   (mem_r_last),
    .r_ready_i  (mem_r_ready),
    .bursts_o   (bursts)
  );

  // aligned words hold address xor pattern, misaligned fetches return zero
  function automatic word_t expected_instr(input addr_t a);
    if (a[1:0] != 2'b00) begin
      return '0;
    end
    return a ^ PATTERN;
  endfunction

  function automatic addr_t random_addr();
    addr_t a;
    a = $urandom & 32'h0000_3ffc;
    if ($urandom % 8 == 0) begin
      a[1:0] = 2'b10;
    end
    return a;
  endfunction

  // ========================================
  // scoreboard and response checks
  // ========================================
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      exp_q.delete();
      req_fire_q <= 1'b0;
      inv_fire_q <= 1'b0;
    end else begin
      req_fire_q <= req_valid && req_ready;
      inv_fire_q <= inv_valid && inv_ready;
      if (rsp_valid && rsp_ready && exp_q.size() > 0) begin
        void'(exp_q.pop_front());
        rsp_count++;
      end
      // flush drops whatever stage 1 holds
      if (flush) begin
        exp_q.delete();
      end else if (req_valid && req_ready) begin
        exp_q.push_back(req_addr);
      end
    end
    exp_cnt   <= exp_q.size();
    exp_head  <= (exp_q.size() > 0) ? exp_q[0] : '0;
    exp_instr <= expected_instr((exp_q.size() > 0) ? exp_q[0] : '0);
  end

  a_known_req: assert property (@(posedge clk) disable iff (!rst_n)
    rsp_valid && rsp_ready |-> exp_cnt > 0)
    else begin
      errors++;
      $display("%s: response arrived with no request outstanding", test_name);
    end

  a_order: assert property (@(posedge clk) disable iff (!rst_n)
    rsp_valid && rsp_ready |-> rsp_addr == exp_head)
    else begin
      errors++;
      $display("ERROR %s: response address expected %h actual %h",
               test_name, $sampled(exp_head), $sampled(rsp_addr));
    end

  a_fault: assert property (@(posedge clk) disable iff (!rst_n)
    rsp_valid && rsp_ready |-> rsp_fault == (exp_head[1:0] != 2'b00))
    else begin
      errors++;
      $display("ERROR %s: fault flag expected %b actual %b",
               test_name, $sampled(exp_head[1:0] != 2'b00), $sampled(rsp_fault));
    end

  a_instr: assert property (@(posedge clk) disable iff (!rst_n)
    rsp_valid && rsp_ready |-> rsp_instr == exp_instr)
    else begin
      errors++;
      $display("ERROR %s: instruction expected %h actual %h",
               test_name, $sampled(exp_instr), $sampled(rsp_instr));
    end

  a_hold: assert property (@(posedge clk) disable iff (!rst_n || flush)
    rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_addr) &&
      $stable(rsp_instr) && $stable(rsp_fault))
    else begin
      errors++;
      $display("%s: response changed while waiting for ready", test_name);
    end

  // ========================================
  // stimulus, driven on the falling edge
  // ========================================
  always @(posedge clk) begin
    bp_q <= bp_en;
  end

  always @(negedge clk) begin
    rsp_ready <= !bp_q || ($urandom % 4 != 0);
  end

  task automatic issue(input addr_t a);
    req_valid = 1'b1;
    req_addr  = a;
    do @(negedge clk); while (!req_fire_q);
    req_valid = 1'b0;
  endtask

  task automatic drain();
    while (exp_cnt != 0) @(negedge clk);
  endtask

  task automatic fetch_one(input addr_t a, input int new_bursts);
    issue(a);
    drain();
    exp_bursts += new_bursts;
    assert (bursts == exp_bursts)
      else begin
        errors++;
        $display("ERROR %s: burst requests expected %0d actual %0d",
                 test_name, exp_bursts, bursts);
      end
  endtask

  task automatic invalidate(input index_t idx, input way_t way);
    inv_valid = 1'b1;
    inv_index = idx;
    inv_way   = way;
    do @(negedge clk); while (!inv_fire_q);
    inv_valid = 1'b0;
  endtask

  initial begin
    void'($urandom(32'he613));
    rst_n     = 1'b0;
    flush     = 1'b0;
    req_valid = 1'b0;
    req_addr  = '0;
    inv_valid = 1'b0;
    inv_index = '0;
    inv_way   = '0;
    repeat (RESET_CYCLES) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    // four words of one line, then the same words again
    test_name = "line_hits";
    for (int pass = 0; pass < 2; pass++) begin
      for (int i = 0; i < LINE_WORDS; i++) begin
        fetch_one(LINE_L + 4 * i, (pass == 0 && i == 0) ? 1 : 0);
      end
    end

    // A to way 0, B to way 1, A hit, then C evicts B
    test_name = "plru";
    fetch_one(LINE_A, 1);
    fetch_one(LINE_B, 1);
    fetch_one(LINE_A, 0);
    fetch_one(LINE_C, 1);
    fetch_one(LINE_A, 0);
    fetch_one(LINE_B, 1);

    test_name = "fault";
    fetch_one(32'h0000_0106, 0);

    // A still sits in way 0 of set 4
    test_name = "invalidate";
    invalidate(LINE_A[OFS_W +: IDX_W], 1'b0);
    fetch_one(LINE_A, 1);

    test_name = "flush";
    issue(LINE_F);
    while (bursts != exp_bursts + 1) @(negedge clk);
    exp_bursts++;
    flush = 1'b1;
    @(negedge clk);
    flush = 1'b0;
    flush_rsp = 1'b0;
    do begin
      @(negedge clk);
      flush_rsp = flush_rsp | rsp_valid;
    end while (mem_r_ready);
    // a surviving fetch would answer two cycles after the line write
    repeat (2) begin
      @(negedge clk);
      flush_rsp = flush_rsp | rsp_valid;
    end
    assert (!flush_rsp)
      else begin
        errors++;
        $display("%s: the flushed fetch still produced a response", test_name);
      end
    fetch_one(LINE_G, 1);
    // the flushed refill still filled its line
    fetch_one(LINE_F, 0);

    test_name = "random_backpressure";
    bp_en = 1'b1;
    for (int n = 0; n < N_RAND; n++) begin
      issue(random_addr());
    end
    drain();
    bp_en = 1'b0;
    @(negedge clk);

    $display("summary: %0d errors, %0d responses checked", errors, rsp_count);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(WATCHDOG_NS);
    $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
    $display("summary: %0d errors, %0d responses checked", errors, rsp_count);
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

// ==== verilog.f ====
logic/icache_pkg.sv
logic/icache_arrays.sv
logic/icache_lookup.sv
logic/icache_refill.sv
logic/icache_top.sv
verification/icache_mem_model.sv
verification/icache_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := icache_tb
FILELIST  := verilog.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
FAIL_MSG  := *** TEST FAILED ***
PASS_MSG  := *** TEST PASSED ***
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qF '$(FAIL_MSG)' $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -qF '$(PASS_MSG)' $(LOG); then echo "simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
